// ==== logic/time_pkg.sv ====
// ----------------------------------------------------------------------
// Shared widths and settings-bus register map for the timebase.
// TIME_W must stay at twice SET_DATA_W, since time is written as two words.
// ----------------------------------------------------------------------
`default_nettype none

package time_pkg;

   localparam int TIME_W     = 64;  // VITA time width
   localparam int SET_ADDR_W = 8;   // Settings address width
   localparam int SET_DATA_W = 32;  // Settings data width

   // Timekeeper registers, relative to its base
   localparam int SR_TIME_HI   = 0;  // Upper load-time word
   localparam int SR_TIME_LO   = 1;  // Lower load-time word
   localparam int SR_TIME_CTRL = 2;  // Load mode {sync, pps, now}, write arms

   // Channel block layout
   localparam int SR_CHAN_BASE   = 16;  // Channel 0 address
   localparam int SR_CHAN_STRIDE = 4;   // Address step per channel
   localparam int CHAN_OFS_HI    = 0;   // Target upper word
   localparam int CHAN_OFS_LO    = 1;   // Target lower word
   localparam int CHAN_OFS_CTRL  = 2;   // Bit 0 arm, bit 1 late enable

   // Collector
   localparam int SR_STATUS_CLR = 8;  // Write-one-to-clear status mask

endpackage

`default_nettype wire

// ==== logic/timekeeper.sv ====
// ----------------------------------------------------------------------
// VITA time counter, loaded now, at the next PPS edge or on sync.
// pps gets only a two-flop edge detector; it must be slow next to clk.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module timekeeper
   import time_pkg::*;
   #(
   parameter int SR_BASE = 0                    // First settings address
   ) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  pps,               // Level, roughly async
   input  logic                  sync,              // One-cycle load pulse
   input  logic                  strobe,            // Time tick
   input  logic                  set_stb,
   input  logic [SET_ADDR_W-1:0] set_addr,
   input  logic [SET_DATA_W-1:0] set_data,
   output logic [TIME_W-1:0]     vita_time,
   output logic [TIME_W-1:0]     vita_time_lastpps
);

   localparam logic [SET_ADDR_W-1:0] ADDR_HI   = SET_ADDR_W'(SR_BASE + SR_TIME_HI);
   localparam logic [SET_ADDR_W-1:0] ADDR_LO   = SET_ADDR_W'(SR_BASE + SR_TIME_LO);
   localparam logic [SET_ADDR_W-1:0] ADDR_CTRL = SET_ADDR_W'(SR_BASE + SR_TIME_CTRL);

   logic [TIME_W-1:0] load_time;     // Value applied on the load event
   logic [2:0]        load_mode;     // {sync, pps, now}
   logic              ctrl_written;  // Control write seen last cycle
   logic              armed;         // Waiting for the load event
   logic              pps_del1;      // First sync flop
   logic              pps_del2;      // Second flop, previous level
   logic              pps_edge;
   logic              time_event;
   logic [TIME_W-1:0] time_next;     // Value vita_time takes at this edge

   // Load-time words
   always_ff @(posedge clk) begin
      if (set_stb && set_addr == ADDR_HI) begin
         load_time[TIME_W-1:SET_DATA_W] <= set_data;
      end
      if (set_stb && set_addr == ADDR_LO) begin
         load_time[SET_DATA_W-1:0] <= set_data;
      end
   end

   // Control register, arming and PPS edge flops
   always_ff @(posedge clk) begin
      if (reset) begin
         load_mode    <= '0;
         ctrl_written <= 1'b0;
         armed        <= 1'b0;
         pps_del1     <= 1'b0;
         pps_del2     <= 1'b0;
      end else begin
         ctrl_written <= set_stb && set_addr == ADDR_CTRL;  // Arms one edge later
         if (set_stb && set_addr == ADDR_CTRL) begin
            load_mode <= set_data[2:0];
         end
         {pps_del2, pps_del1} <= {pps_del1, pps};
         if (ctrl_written) begin
            armed <= 1'b1;
         end else if (time_event) begin
            armed <= 1'b0;                                  // One load per arming
         end
      end
   end

   assign pps_edge   = pps_del1 && !pps_del2;               // Rising edge, two flops late
   assign time_event = armed && (load_mode[0] ||
                                 (load_mode[1] && pps_edge) ||
                                 (load_mode[2] && sync));

   // Load wins over the tick; the strobe in a load cycle is dropped
   always_comb begin
      if (time_event) begin
         time_next = load_time;
      end else if (strobe) begin
         time_next = vita_time + TIME_W'(1);
      end else begin
         time_next = vita_time;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         vita_time         <= '0;
         vita_time_lastpps <= '0;
      end else begin
         vita_time <= time_next;
         if (pps_edge) begin
            vita_time_lastpps <= time_next;                 // Same value as the counter
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/timed_trigger.sv ====
// ----------------------------------------------------------------------
// One timed trigger: fires a single pulse when VITA time reaches target.
// Rewrite the target before arming; a disarming control write cancels it.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module timed_trigger
   import time_pkg::*;
   #(
   parameter int CHAN_ADDR = SR_CHAN_BASE       // Channel register base
   ) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  set_stb,
   input  logic [SET_ADDR_W-1:0] set_addr,
   input  logic [SET_DATA_W-1:0] set_data,
   input  logic [TIME_W-1:0]     vita_time,
   output logic                  trig,          // One-cycle fire pulse
   output logic                  late           // Valid with trig only
);

   localparam logic [SET_ADDR_W-1:0] ADDR_HI   = SET_ADDR_W'(CHAN_ADDR + CHAN_OFS_HI);
   localparam logic [SET_ADDR_W-1:0] ADDR_LO   = SET_ADDR_W'(CHAN_ADDR + CHAN_OFS_LO);
   localparam logic [SET_ADDR_W-1:0] ADDR_CTRL = SET_ADDR_W'(CHAN_ADDR + CHAN_OFS_CTRL);

   logic [TIME_W-1:0] target;     // Fire time
   logic              armed;
   logic              late_en;    // Report late firings
   logic              ctrl_wr;
   logic              at_target;  // vita_time >= target
   logic              past;       // vita_time > target
   logic              hit;        // Fires at this edge

   assign ctrl_wr = set_stb && set_addr == ADDR_CTRL;

   // Target words
   always_ff @(posedge clk) begin
      if (set_stb && set_addr == ADDR_HI) begin
         target[TIME_W-1:SET_DATA_W] <= set_data;
      end
      if (set_stb && set_addr == ADDR_LO) begin
         target[SET_DATA_W-1:0] <= set_data;
      end
   end

   assign at_target = vita_time >= target;
   assign past      = vita_time > target;
   assign hit       = armed && at_target;

   // Compare result registered into the pulse
   always_ff @(posedge clk) begin
      if (reset) begin
         armed   <= 1'b0;
         late_en <= 1'b0;
         trig    <= 1'b0;
         late    <= 1'b0;
      end else begin
         trig <= hit;
         late <= hit && late_en && past;  // Target already gone by
         if (ctrl_wr) begin
            armed   <= set_data[0];
            late_en <= set_data[1];
         end else if (hit) begin
            armed <= 1'b0;                // Single shot
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/event_collector.sv ====
// ----------------------------------------------------------------------
// Sticky fired and late status per channel, with one interrupt level.
// A clear and a new pulse in the same cycle leave the bit set.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module event_collector
   import time_pkg::*;
   #(
   parameter int N_CHANNELS = 4,                // At most 16
   parameter int CLR_ADDR   = SR_STATUS_CLR     // Clear register address
   ) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  set_stb,
   input  logic [SET_ADDR_W-1:0] set_addr,
   input  logic [SET_DATA_W-1:0] set_data,
   input  logic [N_CHANNELS-1:0] trig,
   input  logic [N_CHANNELS-1:0] late,
   output logic [N_CHANNELS-1:0] fired_status,
   output logic [N_CHANNELS-1:0] late_status,
   output logic                  irq
);

   localparam logic [SET_ADDR_W-1:0] ADDR_CLR = SET_ADDR_W'(CLR_ADDR);

   logic [N_CHANNELS-1:0] clr_mask;     // Bits cleared this cycle
   logic [N_CHANNELS-1:0] late_pulse;   // Late flag qualified by its pulse

   always_comb begin
      clr_mask = '0;
      if (set_stb && set_addr == ADDR_CLR) begin
         clr_mask = set_data[N_CHANNELS-1:0];
      end
   end

   assign late_pulse = trig & late;

   always_ff @(posedge clk) begin
      if (reset) begin
         fired_status <= '0;
         late_status  <= '0;
         irq          <= 1'b0;
      end else begin
         fired_status <= (fired_status & ~clr_mask) | trig;       // Set wins
         late_status  <= (late_status & ~clr_mask) | late_pulse;
         irq          <= |fired_status;                          // One cycle behind status
      end
   end

endmodule

`default_nettype wire

// ==== logic/timebase_top.sv ====
// ----------------------------------------------------------------------
// Timebase: VITA time counter, N timed triggers and status collector.
// All blocks share one write-only settings bus with no back-pressure.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module timebase_top
   import time_pkg::*;
   #(
   parameter int N_CHANNELS = 4                 // At most 16
   ) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  pps,
   input  logic                  sync,
   input  logic                  strobe,
   input  logic                  set_stb,
   input  logic [SET_ADDR_W-1:0] set_addr,
   input  logic [SET_DATA_W-1:0] set_data,
   output logic [TIME_W-1:0]     vita_time,
   output logic [TIME_W-1:0]     vita_time_lastpps,
   output logic [N_CHANNELS-1:0] trig,
   output logic [N_CHANNELS-1:0] fired_status,
   output logic [N_CHANNELS-1:0] late_status,
   output logic                  irq
);

   logic [N_CHANNELS-1:0] late;  // Per-channel late flag, valid with trig

   timekeeper #(
      .SR_BASE (SR_TIME_HI)      // Block starts at its high word
   ) timekeeper_i (
      .clk               (clk),
      .reset             (reset),
      .pps               (pps),
      .sync              (sync),
      .strobe            (strobe),
      .set_stb           (set_stb),
      .set_addr          (set_addr),
      .set_data          (set_data),
      .vita_time         (vita_time),
      .vita_time_lastpps (vita_time_lastpps)
   );

   for (genvar i = 0; i < N_CHANNELS; i++) begin : g_chan
      timed_trigger #(
         .CHAN_ADDR (SR_CHAN_BASE + i * SR_CHAN_STRIDE)
      ) trigger_i (
         .clk       (clk),
         .reset     (reset),
         .set_stb   (set_stb),
         .set_addr  (set_addr),
         .set_data  (set_data),
         .vita_time (vita_time),
         .trig      (trig[i]),
         .late      (late[i])
      );
   end

   event_collector #(
      .N_CHANNELS (N_CHANNELS),
      .CLR_ADDR   (SR_STATUS_CLR)
   ) collector_i (
      .clk          (clk),
      .reset        (reset),
      .set_stb      (set_stb),
      .set_addr     (set_addr),
      .set_data     (set_data),
      .trig         (trig),
      .late         (late),
      .fired_status (fired_status),
      .late_status  (late_status),
      .irq          (irq)
   );

endmodule

`default_nettype wire

// ==== tests/timebase_checker.sv ====
// ----------------------------------------------------------------------
// Concurrent checks on the timebase outputs, bound into timebase_top.
// Checks are off while reset is high.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module timebase_checker
   import time_pkg::*;
   #(
   parameter int N_CHANNELS = 4
   ) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [TIME_W-1:0]     vita_time,
   input  logic [TIME_W-1:0]     vita_time_lastpps,
   input  logic [N_CHANNELS-1:0] trig,
   input  logic [N_CHANNELS-1:0] fired_status,
   input  logic [N_CHANNELS-1:0] late_status,
   input  logic                  irq
);

   // Every trigger is a single-cycle pulse
   for (genvar i = 0; i < N_CHANNELS; i++) begin : g_pulse
      assert property (@(posedge clk) disable iff (reset) trig[i] |=> !trig[i])
         else $error("trig %0d high on two cycles in a row", i);
   end

   assert property (@(posedge clk) disable iff (reset) irq == $past(|fired_status))
      else $error("irq does not follow fired_status by one cycle");

   assert property (@(posedge clk) disable iff (reset)
                    !$isunknown({vita_time, vita_time_lastpps, trig,
                                 fired_status, late_status, irq}))
      else $error("unknown value on a timebase output");

endmodule

bind timebase_top timebase_checker #(
   .N_CHANNELS (N_CHANNELS)
) checker_i (
   .clk               (clk),
   .reset             (reset),
   .vita_time         (vita_time),
   .vita_time_lastpps (vita_time_lastpps),
   .trig              (trig),
   .fired_status      (fired_status),
   .late_status       (late_status),
   .irq               (irq)
);

`default_nettype wire

// ==== tests/timebase_tb.sv ====
// ----------------------------------------------------------------------
// Table-driven testbench for timebase_top with four channels.
// Table rows chain: each row starts from the time the previous one left.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module timebase_tb;
   import time_pkg::*;

   localparam int NCH = 4;

   typedef struct packed {
      logic [2:0]  mode;        // Load mode, 0 for no arming
      logic [63:0] load;
      logic [1:0]  ev;          // 0 none, 1 pps, 2 sync
      logic        arm_strobe;  // Strobe during the arming cycles
      logic        ev_strobe;   // Strobe in the event cycle
      logic [7:0]  n;           // Strobes after the event
      logic        ch_en;
      logic [1:0]  ch;
      logic [63:0] target;
      logic [3:0]  arm_delay;
      logic [3:0]  clr;         // Clear mask at row end
      logic [63:0] exp_time;
      logic [63:0] exp_pps;
      logic [63:0] exp_trig;    // vita_time while trig is high
      logic [3:0]  exp_fired;
      logic [3:0]  exp_late;
      logic [3:0]  fired_after; // Status after the clear write
      logic [3:0]  late_after;
   } row_t;

   logic clk, reset, pps, sync, strobe, set_stb;
   logic [SET_ADDR_W-1:0] set_addr;
   logic [SET_DATA_W-1:0] set_data;
   logic [TIME_W-1:0] vita_time, vita_time_lastpps;
   logic [NCH-1:0] trig, fired_status, late_status;
   logic irq;

   row_t        rows[$];
   logic [31:0] lcg_state = 32'd34508;
   int          errors = 0;
   int          passed = 0;
   logic        timed_out = 1'b0;  // A wait ran out, rest of the table skipped
   // Reference model state used while the table is built
   logic [63:0] m_time = '0, m_pps = '0, m_load = '0;
   logic [2:0]  m_mode = '0;
   logic        m_armed = 1'b0;
   logic [3:0]  m_fired = '0, m_late = '0;

   timebase_top #(.N_CHANNELS(NCH)) dut_i (
      .clk (clk), .reset (reset), .pps (pps), .sync (sync), .strobe (strobe),
      .set_stb (set_stb), .set_addr (set_addr), .set_data (set_data),
      .vita_time (vita_time), .vita_time_lastpps (vita_time_lastpps),
      .trig (trig), .fired_status (fired_status), .late_status (late_status),
      .irq (irq)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Appends one row and works out its expected values from the timing rules
   task add_row(input logic [2:0] mode, input logic [63:0] load, input logic [1:0] ev,
                input logic arm_s, input logic ev_s, input logic [7:0] n,
                input logic ch_en, input logic [1:0] ch, input int ofs,
                input logic [3:0] arm_delay, input logic [3:0] clr);
      row_t r;
      r = '0;
      r.mode = mode;
      r.load = load;
      r.ev = ev;
      r.arm_strobe = arm_s;
      r.ev_strobe = ev_s;
      r.n = n;
      r.ch_en = ch_en;
      r.ch = ch;
      r.arm_delay = arm_delay;
      r.clr = clr;
      if (mode != 0) begin
         m_mode = mode;
         m_load = load;
         m_armed = (mode != 3'b001);
         m_time = (mode == 3'b001) ? load + arm_s : m_time + (arm_s ? 3 : 0);  // Only the strobe after the load edge counts
      end
      if (ev == 1) begin
         if (m_armed && m_mode == 3'b010) begin
            m_time = m_load;
            m_armed = 1'b0;
         end else m_time = m_time + ev_s;
         m_pps = m_time;
      end else if (ev == 2) begin
         if (m_armed && m_mode == 3'b100) begin
            m_time = m_load;
            m_armed = 1'b0;
         end else m_time = m_time + ev_s;
      end
      m_time = m_time + n;
      r.exp_time = m_time;
      r.exp_pps = m_pps;
      if (ch_en) begin
         r.target = m_time + 64'(signed'(ofs));
         if (r.target < m_time) m_late[ch] = 1'b1;  // Already past when armed
         if (r.target > m_time) m_time = r.target;
         m_fired[ch] = 1'b1;
      end
      r.exp_trig = m_time;
      r.exp_fired = m_fired;
      r.exp_late = m_late;
      m_fired = m_fired & ~clr;
      m_late = m_late & ~clr;
      r.fired_after = m_fired;
      r.late_after = m_late;
      rows.push_back(r);
   endtask

   task drive(input logic stb, input logic [7:0] a, input logic [31:0] d,
              input logic str, input logic sy);
      @(posedge clk);
      set_stb <= stb;
      set_addr <= a;
      set_data <= d;
      strobe <= str;
      sync <= sy;
   endtask

   task write_reg(input logic [7:0] a, input logic [31:0] d);
      drive(1'b1, a, d, 1'b0, 1'b0);
   endtask

   task idle(input int n, input logic str);
      repeat (n) drive(1'b0, 8'd0, 32'd0, str, 1'b0);
   endtask

   task compare(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task check_status(input logic [3:0] fired, input logic [3:0] late);
      @(negedge clk);
      compare(fired_status, fired, "fired_status");
      compare(late_status, late, "late_status");
      compare(irq, |fired, "irq");
   endtask

   // Arms the channel and steps time one strobe per three cycles until it fires
   task run_trigger(input row_t r);
      int cnt, post, iter, phase;
      logic [63:0] t_at;
      cnt = 0;
      post = 0;
      iter = 0;
      phase = 1;
      t_at = '0;
      write_reg(SR_CHAN_BASE + r.ch * SR_CHAN_STRIDE + CHAN_OFS_HI, r.target[63:32]);
      write_reg(SR_CHAN_BASE + r.ch * SR_CHAN_STRIDE + CHAN_OFS_LO, r.target[31:0]);
      idle(r.arm_delay, 1'b0);
      write_reg(SR_CHAN_BASE + r.ch * SR_CHAN_STRIDE + CHAN_OFS_CTRL, 32'h3);
      while (post < 4 && iter < 300) begin
         @(negedge clk);
         if (trig[r.ch]) begin
            cnt++;
            t_at = vita_time;
         end
         if ((trig & ~(4'b1 << r.ch)) != 0) begin
            $display("ERROR %0t: trig %b on a channel not armed", $time, trig);
            errors++;
         end
         if (cnt > 0) post++;
         drive(1'b0, 8'd0, 32'd0, cnt == 0 && phase == 0, 1'b0);
         phase = (phase + 1) % 3;
         iter++;
      end
      if (post < 4) begin
         $display("Timeout waiting for the trigger on channel %0d", r.ch);
         timed_out = 1'b1;
      end else begin
         if (cnt != 1) begin
            $display("ERROR %0t: channel %0d pulsed %0d times", $time, r.ch, cnt);
            errors++;
         end
         compare(t_at, r.exp_trig, "vita_time at trig");
      end
   endtask

   task run_row(input int idx, input row_t r);
      int err0;
      err0 = errors;
      if (r.mode != 0) begin
         write_reg(SR_TIME_HI, r.load[63:32]);
         write_reg(SR_TIME_LO, r.load[31:0]);
         write_reg(SR_TIME_CTRL, {29'd0, r.mode});
         idle(3, r.arm_strobe);                    // Load lands on the third edge
         idle(1, 1'b0);
      end
      if (r.ev == 1) begin
         @(posedge clk);
         pps <= 1'b1;
         idle(1, r.ev_strobe);                     // Lines up with the detected edge
         idle(3, 1'b0);
         pps <= 1'b0;
         idle(3, 1'b0);
      end else if (r.ev == 2) begin
         drive(1'b0, 8'd0, 32'd0, r.ev_strobe, 1'b1);
         idle(2, 1'b0);
      end
      repeat (r.n) begin
         idle(1, 1'b1);
         idle(1, 1'b0);
      end
      idle(2, 1'b0);
      @(negedge clk);
      compare(vita_time, r.exp_time, "vita_time");
      compare(vita_time_lastpps, r.exp_pps, "vita_time_lastpps");
      if (r.ch_en) begin
         run_trigger(r);
         if (!timed_out) check_status(r.exp_fired, r.exp_late);
      end
      if (r.clr != 0 && !timed_out) begin
         write_reg(SR_STATUS_CLR, {28'd0, r.clr});
         idle(3, 1'b0);
         check_status(r.fired_after, r.late_after);
      end
      if (errors == err0 && !timed_out) begin
         passed++;
         $display("Row %0d ok", idx);
      end else $display("Row %0d FAILED", idx);
   endtask

   initial begin
      reset = 1'b1;
      pps = 1'b0;
      sync = 1'b0;
      strobe = 1'b0;
      set_stb = 1'b0;
      set_addr = '0;
      set_data = '0;
      // mode, load, ev, arm_s, ev_s, n, ch_en, ch, ofs, arm_delay, clr
      add_row(3'b001, 64'h0000_0001_FFFF_FFF0, 0, 1, 0, 20, 0, 0, 0, 0, 0);
      add_row(3'b010, 64'h1234_5678_0000_0100, 0, 1, 0, 5, 0, 0, 0, 0, 0);
      add_row(3'b000, 64'h0, 1, 0, 0, 0, 0, 0, 0, 0, 0);   // Armed PPS load
      add_row(3'b000, 64'h0, 1, 0, 1, 0, 0, 0, 0, 0, 0);   // Capture only
      add_row(3'b100, 64'h00AB_0000_0000_1000, 1, 1, 1, 4, 0, 0, 0, 0, 0);
      add_row(3'b000, 64'h0, 2, 0, 0, 0, 0, 0, 0, 0, 0);   // Sync load
      add_row(3'b000, 64'h0, 2, 0, 1, 2, 0, 0, 0, 0, 0);   // No longer armed
      add_row(3'b000, 64'h0, 0, 0, 0, 0, 1, 1, 7, 2, 0);   // On time
      add_row(3'b000, 64'h0, 0, 0, 0, 0, 1, 2, -5, 1, 4'b0010);
      add_row(3'b000, 64'h0, 0, 0, 0, 0, 0, 0, 0, 0, 4'b0100);
      repeat (6) begin
         add_row(3'b001, {lcg_next(), lcg_next()} | 64'h100, 0, 0, 0, 8'(lcg_next() % 8),
                 1, 2'(lcg_next() % 4), int'(lcg_next() % 16) - 8, 4'(lcg_next() % 4), 4'hF);
      end
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      idle(2, 1'b0);
      for (int i = 0; i < rows.size() && !timed_out; i++) run_row(i, rows[i]);
      $display("%0d of %0d rows ok, %0d errors", passed, rows.size(), errors);
      if (errors == 0 && passed == rows.size()) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/time_pkg.sv
logic/timekeeper.sv
logic/timed_trigger.sv
logic/event_collector.sv
logic/timebase_top.sv
tests/timebase_checker.sv
tests/timebase_tb.sv
